// File: source/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // Operand and result word of the execute stage.
    typedef logic [31:0] word_t;

    // Full product, or remainder and quotient side by side.
    typedef logic [63:0] product_t;

    typedef enum logic [1:0] {
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU
    } md_op_t;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_MUL_BUSY,
        MD_DIV_BUSY
    } md_state_t;

    typedef logic [5:0] cycle_t;

    // Register stages inside the multiplier, start to done.
    localparam int MUL_STAGES = 4;

    // Edges from the en sampling edge to the edge that raises res_ready.
    // One edge to issue start, the unit itself, one edge to register res_ready.
    localparam cycle_t MUL_LATENCY = cycle_t'(MUL_STAGES + 2);

    // One load edge and 32 iterations inside the divider.
    localparam cycle_t DIV_LATENCY = cycle_t'(35);

endpackage

`default_nettype wire

// File: source/muldiv_if.sv
`timescale 1ns/100ps
`default_nettype none

interface muldiv_if;
    import muldiv_pkg::*;

    logic  start;
    logic  signed_op;
    word_t a;
    word_t b;
    word_t hi;
    word_t lo;
    logic  done;

    // Operands are valid with start, results hold from done to the next start.
    modport ctrl (
        output start,
        output signed_op,
        output a,
        output b,
        input  hi,
        input  lo,
        input  done
    );

    modport unit (
        input  start,
        input  signed_op,
        input  a,
        input  b,
        output hi,
        output lo,
        output done
    );

endinterface

`default_nettype wire

// File: source/mul_staged.sv
`timescale 1ns/100ps
`default_nettype none

module mul_staged (
    input wire     clk,
    input wire     rst,
    muldiv_if.unit bus
);
    import muldiv_pkg::*;

    logic [MUL_STAGES-1:0] vld;

    // Stage 1.
    word_t a_mag;
    word_t b_mag;
    logic  neg_s1;

    // Stage 2.
    logic [31:0] pp_ll;
    logic [31:0] pp_lh;
    logic [31:0] pp_hl;
    logic [31:0] pp_hh;
    logic        neg_s2;

    // Stage 3.
    product_t mag_prod;
    logic     neg_s3;

    product_t res_prod;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[MUL_STAGES-2:0], bus.start};
        end
    end

    // Signed operands are multiplied as magnitudes.
    always_ff @(posedge clk) begin
        if (bus.start) begin
            if (bus.signed_op) begin
                a_mag  <= bus.a[31] ? -bus.a : bus.a;
                b_mag  <= bus.b[31] ? -bus.b : bus.b;
                neg_s1 <= bus.a[31] ^ bus.b[31];
            end else begin
                a_mag  <= bus.a;
                b_mag  <= bus.b;
                neg_s1 <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vld[0]) begin
            pp_ll  <= a_mag[15:0] * b_mag[15:0];
            pp_lh  <= a_mag[15:0] * b_mag[31:16];
            pp_hl  <= a_mag[31:16] * b_mag[15:0];
            pp_hh  <= a_mag[31:16] * b_mag[31:16];
            neg_s2 <= neg_s1;
        end
    end

    // Cross terms sit 16 bits up.
    always_ff @(posedge clk) begin
        if (vld[1]) begin
            mag_prod <= {pp_hh, pp_ll}
                      + (product_t'(pp_lh) << 16)
                      + (product_t'(pp_hl) << 16);
            neg_s3   <= neg_s2;
        end
    end

    assign res_prod = neg_s3 ? -mag_prod : mag_prod;

    always_ff @(posedge clk) begin
        if (vld[2]) begin
            bus.hi <= res_prod[63:32];
            bus.lo <= res_prod[31:0];
        end
    end

    assign bus.done = vld[MUL_STAGES-1];

endmodule

`default_nettype wire

// File: source/div_restoring.sv
`timescale 1ns/100ps
`default_nettype none

module div_restoring (
    input wire     clk,
    input wire     rst,
    muldiv_if.unit bus
);
    import muldiv_pkg::*;

    localparam int W = $bits(word_t);
    localparam int CNT_W = $clog2(W);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(W - 1);

    logic             busy;
    logic [CNT_W-1:0] iter_cnt;

    word_t dividend;
    word_t dvs;
    word_t rem;
    word_t quo;
    logic  q_neg;
    logic  r_neg;
    logic  div_zero;
    logic  ovf;

    logic [W:0] rem_shift;
    logic [W:0] rem_diff;
    logic       fits;
    word_t      rem_next;
    word_t      quo_next;

    // Quotient bits shift in at the bottom as dividend bits shift out the top.
    assign rem_shift = {rem, quo[W-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs};
    assign fits      = rem_shift >= {1'b0, dvs};
    assign rem_next  = fits ? rem_diff[W-1:0] : rem_shift[W-1:0];
    assign quo_next  = {quo[W-2:0], fits};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            iter_cnt <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.start) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end else if (busy) begin
                iter_cnt <= iter_cnt + 1'b1;
                if (iter_cnt == LAST_ITER) begin
                    busy     <= 1'b0;
                    bus.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            dividend <= bus.a;
            rem      <= '0;
            if (bus.signed_op) begin
                quo   <= bus.a[W-1] ? -bus.a : bus.a;
                dvs   <= bus.b[W-1] ? -bus.b : bus.b;
                q_neg <= bus.a[W-1] ^ bus.b[W-1];
                r_neg <= bus.a[W-1];
            end else begin
                quo   <= bus.a;
                dvs   <= bus.b;
                q_neg <= 1'b0;
                r_neg <= 1'b0;
            end
            div_zero <= (bus.b == '0);
            // Most negative value divided by minus one.
            ovf      <= bus.signed_op && (bus.a == {1'b1, {(W-1){1'b0}}}) && (bus.b == '1);
        end else if (busy) begin
            rem <= rem_next;
            quo <= quo_next;
        end
    end

    // Results land on the last iteration edge, together with done.
    always_ff @(posedge clk) begin
        if (busy && (iter_cnt == LAST_ITER)) begin
            if (div_zero) begin
                bus.hi <= dividend;
                bus.lo <= '1;
            end else if (ovf) begin
                bus.hi <= '0;
                bus.lo <= dividend;
            end else begin
                bus.hi <= r_neg ? -rem_next : rem_next;
                bus.lo <= q_neg ? -quo_next : quo_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/muldiv_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_ctrl (
    input wire                 clk,
    input wire                 rst,
    input wire                 en,
    input wire muldiv_pkg::md_op_t op,
    input wire muldiv_pkg::word_t  src_a,
    input wire muldiv_pkg::word_t  src_b,
    muldiv_if.ctrl             mul_bus,
    muldiv_if.ctrl             div_bus,
    output muldiv_pkg::word_t  hi,
    output muldiv_pkg::word_t  lo,
    output logic               res_ready,
    output logic               stall
);
    import muldiv_pkg::*;

    md_state_t state;
    cycle_t    busy_cnt;

    logic  accept;
    logic  is_div;
    logic  is_signed;
    logic  unit_done;
    logic  mul_start;
    logic  div_start;
    word_t a_q;
    word_t b_q;
    logic  signed_q;

    always_comb begin
        is_div    = 1'b0;
        is_signed = 1'b0;
        case (op)
            MD_MULT: begin
                is_signed = 1'b1;
            end
            MD_MULTU: begin
                is_signed = 1'b0;
            end
            MD_DIV: begin
                is_div    = 1'b1;
                is_signed = 1'b1;
            end
            MD_DIVU: begin
                is_div    = 1'b1;
            end
            default: begin
                is_div    = 1'b0;
            end
        endcase
    end

    // No new operation in the res_ready cycle, so stall stays low there.
    assign accept = en && (state == MD_IDLE) && !res_ready;
    assign stall  = accept || (state != MD_IDLE);

    assign unit_done = ((state == MD_MUL_BUSY) && mul_bus.done)
                    || ((state == MD_DIV_BUSY) && div_bus.done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= MD_IDLE;
            busy_cnt  <= '0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            res_ready <= 1'b0;
            hi        <= '0;
            lo        <= '0;
        end else begin
            res_ready <= 1'b0;
            // Start goes out on the first busy edge.
            mul_start <= (state == MD_MUL_BUSY) && (busy_cnt == '0);
            div_start <= (state == MD_DIV_BUSY) && (busy_cnt == '0);
            case (state)
                MD_IDLE: begin
                    if (accept) begin
                        state    <= is_div ? MD_DIV_BUSY : MD_MUL_BUSY;
                        busy_cnt <= '0;
                    end
                end
                MD_MUL_BUSY, MD_DIV_BUSY: begin
                    if (busy_cnt != '1) begin
                        busy_cnt <= busy_cnt + 1'b1;
                    end
                    if (unit_done) begin
                        state     <= MD_IDLE;
                        res_ready <= 1'b1;
                        hi        <= (state == MD_DIV_BUSY) ? div_bus.hi : mul_bus.hi;
                        lo        <= (state == MD_DIV_BUSY) ? div_bus.lo : mul_bus.lo;
                    end
                end
                default: begin
                    state <= MD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q      <= src_a;
            b_q      <= src_b;
            signed_q <= is_signed;
        end
    end

    // Both units see the same held operands; only one gets a start.
    assign mul_bus.start     = mul_start;
    assign mul_bus.signed_op = signed_q;
    assign mul_bus.a         = a_q;
    assign mul_bus.b         = b_q;

    assign div_bus.start     = div_start;
    assign div_bus.signed_op = signed_q;
    assign div_bus.a         = a_q;
    assign div_bus.b         = b_q;

endmodule

`default_nettype wire

// File: source/muldiv_top.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_top (
    input wire                     clk,
    input wire                     rst,
    input wire                     en,
    input wire muldiv_pkg::md_op_t op,
    input wire muldiv_pkg::word_t  src_a,
    input wire muldiv_pkg::word_t  src_b,
    output wire muldiv_pkg::word_t hi,
    output wire muldiv_pkg::word_t lo,
    output wire                    res_ready,
    output wire                    stall
);

    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    muldiv_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .op        (op),
        .src_a     (src_a),
        .src_b     (src_b),
        .mul_bus   (mul_bus.ctrl),
        .div_bus   (div_bus.ctrl),
        .hi        (hi),
        .lo        (lo),
        .res_ready (res_ready),
        .stall     (stall)
    );

    mul_staged u_mul (
        .clk (clk),
        .rst (rst),
        .bus (mul_bus.unit)
    );

    div_restoring u_div (
        .clk (clk),
        .rst (rst),
        .bus (div_bus.unit)
    );

endmodule

`default_nettype wire

// File: bench/muldiv_assert.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_assert (
    input wire                        clk,
    input wire                        rst,
    input wire muldiv_pkg::md_state_t state,
    input wire                        res_ready,
    input wire                        stall
);
    import muldiv_pkg::*;

    // Once raised, stall is held by a busy unit until the result arrives.
    stall_until_ready: assert property (@(posedge clk) disable iff (rst)
        (stall && !res_ready) |=> ((state != MD_IDLE) || res_ready))
        else $error("stall was released without a res_ready pulse");

    ready_one_cycle: assert property (@(posedge clk) disable iff (rst)
        res_ready |=> !res_ready)
        else $error("res_ready stayed high for more than one cycle");

    // The pipeline is released in the result cycle.
    ready_no_stall: assert property (@(posedge clk) disable iff (rst)
        res_ready |-> !stall)
        else $error("res_ready and stall are high together");

endmodule

bind muldiv_ctrl muldiv_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .res_ready (res_ready),
    .stall     (stall)
);

`default_nettype wire

// File: bench/muldiv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;
    import muldiv_pkg::*;

    logic   clk;
    logic   rst;
    logic   en;
    md_op_t op;
    word_t  src_a;
    word_t  src_b;
    word_t  hi;
    word_t  lo;
    logic   res_ready;
    logic   stall;

    muldiv_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .op        (op),
        .src_a     (src_a),
        .src_b     (src_b),
        .hi        (hi),
        .lo        (lo),
        .res_ready (res_ready),
        .stall     (stall)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s expected %08h actual %08h", name, expected, actual));
        end
    endtask

    task automatic check_cycles(input string name, input cycle_t expected, input cycle_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // Reference results: hi holds the upper product word or the remainder.
    function automatic product_t model_result(input md_op_t kind, input word_t a, input word_t b);
        longint   sa;
        longint   sb;
        longint   q;
        longint   r;
        product_t res;
        sa = $signed(a);
        sb = $signed(b);
        res = '0;
        case (kind)
            MD_MULT: res = product_t'(sa * sb);
            MD_MULTU: res = {32'h0, a} * {32'h0, b};
            MD_DIV: begin
                if (b == 32'h0) begin
                    res = {a, 32'hffff_ffff};
                end else if ((a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
                    res = {32'h0, a};
                end else begin
                    q = sa / sb;
                    r = sa % sb;
                    res = {r[31:0], q[31:0]};
                end
            end
            default: begin
                if (b == 32'h0) begin
                    res = {a, 32'hffff_ffff};
                end else begin
                    res = {a % b, a / b};
                end
            end
        endcase
        return res;
    endfunction

    function automatic word_t pick_operand();
        case ($urandom_range(7, 0))
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            4: return 32'h7fff_ffff;
            default: return $urandom();
        endcase
    endfunction

    // Drives junk requests while the unit is busy, or releases en.
    task automatic drive_busy_inputs(input bit noise);
        if (noise) begin
            en    <= 1'b1;
            op    <= md_op_t'($urandom_range(3, 0));
            src_a <= $urandom();
            src_b <= $urandom();
        end else begin
            en <= 1'b0;
        end
    endtask

    task automatic run_op(input string name, input md_op_t kind, input word_t a,
                          input word_t b, input bit noise);
        product_t expected;
        word_t    prev_hi;
        word_t    prev_lo;
        cycle_t   latency;
        int       waited;
        bit       seen;
        expected = model_result(kind, a, b);
        latency  = ((kind == MD_DIV) || (kind == MD_DIVU)) ? DIV_LATENCY : MUL_LATENCY;
        prev_hi  = hi;
        prev_lo  = lo;
        @(posedge clk);
        en    <= 1'b1;
        op    <= kind;
        src_a <= a;
        src_b <= b;
        @(negedge clk);
        check_flag({name, " stall on en"}, 1'b1, stall);
        // Edge that samples en.
        @(posedge clk);
        drive_busy_inputs(noise);
        @(negedge clk);
        check_flag({name, " stall busy"}, 1'b1, stall);
        waited = 0;
        seen   = 1'b0;
        while (!seen && (waited < 64)) begin
            @(posedge clk);
            waited = waited + 1;
            drive_busy_inputs(noise && (waited < 3));
            @(negedge clk);
            if (res_ready) begin
                seen = 1'b1;
            end else begin
                check_flag({name, " stall busy"}, 1'b1, stall);
                check_word({name, " hi hold"}, prev_hi, hi);
                check_word({name, " lo hold"}, prev_lo, lo);
            end
        end
        if (!seen) begin
            fail_run($sformatf("%s never raised res_ready within 64 cycles", name));
        end
        check_cycles({name, " latency"}, latency, cycle_t'(waited));
        check_flag({name, " stall at ready"}, 1'b0, stall);
        check_word({name, " hi"}, expected[63:32], hi);
        check_word({name, " lo"}, expected[31:0], lo);
    endtask

    initial begin
        md_op_t kind;
        void'($urandom(32'had0fb98c));
        clk   = 1'b0;
        rst   = 1'b1;
        en    = 1'b0;
        op    = MD_MULT;
        src_a = '0;
        src_b = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("reset stall", 1'b0, stall);
        check_flag("reset res_ready", 1'b0, res_ready);
        check_word("reset hi", 32'h0, hi);
        check_word("reset lo", 32'h0, lo);

        run_op("mult min by min", MD_MULT, 32'h8000_0000, 32'h8000_0000, 1'b0);
        run_op("multu max by max", MD_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
        run_op("mult max by min", MD_MULT, 32'h7fff_ffff, 32'h8000_0000, 1'b0);
        run_op("mult minus one", MD_MULT, 32'hffff_ffff, 32'h0000_0007, 1'b0);
        run_op("div basic", MD_DIV, 32'hffff_ff9c, 32'h0000_0007, 1'b0);
        run_op("div by zero", MD_DIV, 32'h0000_3039, 32'h0, 1'b0);
        run_op("divu by zero", MD_DIVU, 32'hffff_0000, 32'h0, 1'b0);
        run_op("div overflow", MD_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_op("divu no overflow", MD_DIVU, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_op("mult busy en", MD_MULT, 32'h1234_5678, 32'hfedc_ba98, 1'b1);
        run_op("div busy en", MD_DIV, 32'h8765_4321, 32'h0000_0123, 1'b1);

        for (int i = 0; i < 60; i++) begin
            kind = md_op_t'($urandom_range(3, 0));
            run_op($sformatf("random %0d %s", i, kind.name()), kind, pick_operand(),
                   pick_operand(), ($urandom_range(3, 0) == 0));
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: muldiv_unit.f
source/muldiv_pkg.sv
source/muldiv_if.sv
source/mul_staged.sv
source/div_restoring.sv
source/muldiv_ctrl.sv
source/muldiv_top.sv
bench/muldiv_assert.sv
bench/muldiv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the multiply/divide unit testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f muldiv_unit.f \
    --top-module muldiv_tb \
    -o muldiv_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/muldiv_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit "$sim_status"
fi

echo "Simulation finished"
exit 0
